// File: design/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [exec_pkg::XLEN-1:0] a_i,
    input  logic [exec_pkg::XLEN-1:0] b_i,
    input  logic [3:0]                op_i,
    output logic [exec_pkg::XLEN-1:0] result_o
);

    import exec_pkg::*;

    logic [SHAMT_W-1:0] shamt;
    logic               lt_signed;
    logic               lt_unsigned;

    assign shamt       = b_i[SHAMT_W-1:0];
    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    always_comb begin
        case (op_i)
            ALU_ADD:    result_o = a_i + b_i;
            ALU_SUB:    result_o = a_i - b_i;
            ALU_SLL:    result_o = a_i << shamt;
            ALU_SLT:    result_o = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU:   result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:    result_o = a_i ^ b_i;
            ALU_SRL:    result_o = a_i >> shamt;
            ALU_SRA:    result_o = $unsigned($signed(a_i) >>> shamt);
            ALU_OR:     result_o = a_i | b_i;
            ALU_AND:    result_o = a_i & b_i;
            ALU_PASS_A: result_o = a_i;
            // Unused codes fall back to add
            default:    result_o = a_i + b_i;
        endcase
    end

endmodule

// File: design/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                             inst_valid_i,
    input  logic [exec_pkg::XLEN-1:0]        inst_i,
    input  logic [exec_pkg::XLEN-1:0]        pc_i,
    output logic [exec_pkg::REG_ADDR_W-1:0]  rs1_addr_o,
    output logic [exec_pkg::REG_ADDR_W-1:0]  rs2_addr_o,
    input  logic [exec_pkg::XLEN-1:0]        rs1_data_i,
    input  logic [exec_pkg::XLEN-1:0]        rs2_data_i,
    input  exec_pkg::wb_s                    wb_i,
    output exec_pkg::id_ex_s                 id_ex_o
);

    import exec_pkg::*;

    inst_word_u      inst;
    logic [6:0]      opcode;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;

    assign inst   = inst_i;
    assign opcode = inst.r_view.opcode;

    assign rs1_addr_o = inst.i_view.rs1;
    assign rs2_addr_o = inst.r_view.rs2;

    // Sign-extended I immediate
    assign imm_i = {{(XLEN-12){inst.i_view.imm12[11]}}, inst.i_view.imm12};

    // U immediate spans imm12, rs1 and funct3 of the I layout
    assign imm_u = {inst.i_view.imm12, inst.i_view.rs1, inst.i_view.funct3, 12'b0};

    // Bypass the result being written back this cycle
    always_comb begin
        rs1_val = rs1_data_i;
        rs2_val = rs2_data_i;
        if (wb_i.valid && (wb_i.rd == rs1_addr_o)) begin
            rs1_val = wb_i.data;
        end
        if (wb_i.valid && (wb_i.rd == rs2_addr_o)) begin
            rs2_val = wb_i.data;
        end
    end

    always_comb begin
        case (opcode)
            OPCODE_AUIPC: begin
                op1 = pc_i;
            end
            OPCODE_LUI: begin
                op1 = '0;
            end
            default: begin
                op1 = rs1_val;
            end
        endcase
    end

    always_comb begin
        case (opcode)
            OPCODE_LUI, OPCODE_AUIPC: begin
                op2 = imm_u;
            end
            OPCODE_OP_IMM, OPCODE_LOAD: begin
                op2 = imm_i;
            end
            default: begin
                op2 = rs2_val;
            end
        endcase
    end

    always_comb begin
        id_ex_o.valid    = inst_valid_i;
        id_ex_o.pc       = pc_i;
        id_ex_o.inst     = inst;
        id_ex_o.op1      = op1;
        id_ex_o.op2      = op2;
        id_ex_o.rs2_data = rs2_val;
        id_ex_o.rd       = inst.r_view.rd;
    end

endmodule

// File: design/exec_pkg.sv
package exec_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = $clog2(XLEN);

    localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;

    // Major opcodes handled by this slice
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
    localparam logic [6:0] OPCODE_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;

    // ALU operation codes
    localparam logic [3:0] ALU_ADD    = 4'd0;
    localparam logic [3:0] ALU_SUB    = 4'd1;
    localparam logic [3:0] ALU_SLL    = 4'd2;
    localparam logic [3:0] ALU_SLT    = 4'd3;
    localparam logic [3:0] ALU_SLTU   = 4'd4;
    localparam logic [3:0] ALU_XOR    = 4'd5;
    localparam logic [3:0] ALU_SRL    = 4'd6;
    localparam logic [3:0] ALU_SRA    = 4'd7;
    localparam logic [3:0] ALU_OR     = 4'd8;
    localparam logic [3:0] ALU_AND    = 4'd9;
    localparam logic [3:0] ALU_PASS_A = 4'd10;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_type_s;

    typedef struct packed {
        logic [11:0]           imm12;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } i_type_s;

    // Same word seen as R-type or I-type
    typedef union packed {
        r_type_s r_view;
        i_type_s i_view;
    } inst_word_u;

    // Decode to execute bundle
    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        inst_word_u            inst;
        logic [XLEN-1:0]       op1;
        logic [XLEN-1:0]       op2;
        logic [XLEN-1:0]       rs2_data;
        logic [REG_ADDR_W-1:0] rd;
    } id_ex_s;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_s;

endpackage

// File: design/exec_slice_top.sv
`timescale 1ns/1ps

module exec_slice_top (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      inst_valid_i,
    input  logic [exec_pkg::XLEN-1:0] inst_i,
    input  logic [exec_pkg::XLEN-1:0] pc_i,
    output exec_pkg::wb_s             wb_o,
    output logic                      dmem_req_o,
    output logic [exec_pkg::XLEN-1:0] dmem_addr_o,
    output logic [exec_pkg::XLEN-1:0] ex_pc_o,
    output logic [exec_pkg::XLEN-1:0] ex_inst_o
);

    import exec_pkg::*;

    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    id_ex_s                id_ex;

    register_file register_file_i (
        .clk        (clk),
        .reset_i    (reset_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb_i       (wb_o)
    );

    decode_stage decode_stage_i (
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .wb_i         (wb_o),
        .id_ex_o      (id_ex)
    );

    execute_stage execute_stage_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .id_ex_i     (id_ex),
        .wb_o        (wb_o),
        .dmem_req_o  (dmem_req_o),
        .dmem_addr_o (dmem_addr_o),
        .ex_pc_o     (ex_pc_o),
        .ex_inst_o   (ex_inst_o)
    );

endmodule

// File: design/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic                      clk,
    input  logic                      reset_i,
    input  exec_pkg::id_ex_s          id_ex_i,
    output exec_pkg::wb_s             wb_o,
    output logic                      dmem_req_o,
    output logic [exec_pkg::XLEN-1:0] dmem_addr_o,
    output logic [exec_pkg::XLEN-1:0] ex_pc_o,
    output logic [exec_pkg::XLEN-1:0] ex_inst_o
);

    import exec_pkg::*;

    id_ex_s          id_ex_q;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            alt_bit;
    logic [3:0]      alu_op;
    logic [XLEN-1:0] alu_result;
    logic            writes_rd;

    // Pipeline register between decode and execute
    always_ff @(posedge clk) begin
        id_ex_q <= id_ex_i;
        if (reset_i) begin
            id_ex_q.valid <= 1'b0;
            id_ex_q.pc    <= RESET_PC;
            id_ex_q.inst  <= '0;
        end
    end

    assign opcode  = id_ex_q.inst.r_view.opcode;
    assign funct3  = id_ex_q.inst.i_view.funct3;
    assign alt_bit = id_ex_q.inst.r_view.funct7[5];

    // ALU control
    always_comb begin
        alu_op = ALU_ADD;
        if ((opcode == OPCODE_OP) || (opcode == OPCODE_OP_IMM)) begin
            case (funct3)
                3'b000: begin
                    // Immediate form has no subtract
                    if ((opcode == OPCODE_OP) && alt_bit) begin
                        alu_op = ALU_SUB;
                    end else begin
                        alu_op = ALU_ADD;
                    end
                end
                3'b001: alu_op = ALU_SLL;
                3'b010: alu_op = ALU_SLT;
                3'b011: alu_op = ALU_SLTU;
                3'b100: alu_op = ALU_XOR;
                3'b101: alu_op = alt_bit ? ALU_SRA : ALU_SRL;
                3'b110: alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end
    end

    alu alu_i (
        .a_i      (id_ex_q.op1),
        .b_i      (id_ex_q.op2),
        .op_i     (alu_op),
        .result_o (alu_result)
    );

    always_comb begin
        case (opcode)
            OPCODE_OP, OPCODE_OP_IMM, OPCODE_LUI, OPCODE_AUIPC: writes_rd = 1'b1;
            default: writes_rd = 1'b0;
        endcase
    end

    // Write-back never targets x0
    always_comb begin
        wb_o.valid = id_ex_q.valid && writes_rd && (id_ex_q.rd != '0);
        wb_o.rd    = id_ex_q.rd;
        wb_o.data  = alu_result;
    end

    assign dmem_req_o  = id_ex_q.valid && (opcode == OPCODE_LOAD);
    assign dmem_addr_o = alu_result;

    assign ex_pc_o   = id_ex_q.pc;
    assign ex_inst_o = id_ex_q.inst;

endmodule

// File: design/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                             clk,
    input  logic                             reset_i,
    input  logic [exec_pkg::REG_ADDR_W-1:0]  rs1_addr_i,
    input  logic [exec_pkg::REG_ADDR_W-1:0]  rs2_addr_i,
    output logic [exec_pkg::XLEN-1:0]        rs1_data_o,
    output logic [exec_pkg::XLEN-1:0]        rs2_data_o,
    input  exec_pkg::wb_s                    wb_i
);

    import exec_pkg::*;

    // x0 has no storage
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.valid && (wb_i.rd != '0)) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    always_comb begin
        rs1_data_o = '0;
        rs2_data_o = '0;
        if (rs1_addr_i != '0) begin
            rs1_data_o = regs[rs1_addr_i];
        end
        if (rs2_addr_i != '0) begin
            rs2_data_o = regs[rs2_addr_i];
        end
    end

endmodule

// File: files.f
design/exec_pkg.sv
design/register_file.sv
design/decode_stage.sv
design/alu.sv
design/execute_stage.sv
design/exec_slice_top.sv
testbench/exec_slice_properties.sv
testbench/exec_slice_tb.sv

// File: testbench/exec_slice_properties.sv
`timescale 1ns/1ps

module exec_slice_properties (
    input logic          clk,
    input logic          reset_i,
    input logic          inst_valid_i,
    input exec_pkg::wb_s wb_o,
    input logic          dmem_req_o
);

    int violations = 0;

    // A load never writes back
    one_output_a: assert property (@(posedge clk) disable iff (reset_i)
        !(wb_o.valid && dmem_req_o))
        else begin
            violations++;
            $error("write-back and memory request active in the same cycle");
        end

    rd_nonzero_a: assert property (@(posedge clk) disable iff (reset_i)
        wb_o.valid |-> (wb_o.rd != '0))
        else begin
            violations++;
            $error("write-back targets x0");
        end

    // Fixed one-cycle latency from the strobe
    follows_strobe_a: assert property (@(posedge clk) disable iff (reset_i)
        (wb_o.valid || dmem_req_o) |-> $past(inst_valid_i))
        else begin
            violations++;
            $error("output active without a strobe one cycle earlier");
        end

    quiet_after_reset_a: assert property (@(posedge clk)
        reset_i |=> (!wb_o.valid && !dmem_req_o))
        else begin
            violations++;
            $error("output active during reset or in the cycle after it");
        end

endmodule

// File: testbench/exec_slice_tb.sv
`timescale 1ns/1ps

module exec_slice_tb;

    import exec_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 4;
    localparam int N_RANDOM     = 200;
    localparam int N_DEP        = 40;
    localparam int N_INSTS      = 62 + N_RANDOM + N_DEP + 1;
    localparam int N_IDLE       = N_DEP / 2 + 10;

    // Data carries the load address when req is set
    typedef struct packed {
        logic            wb_valid;
        logic            req;
        logic [4:0]      rd;
        logic [XLEN-1:0] data;
        logic [XLEN-1:0] inst;
        logic [XLEN-1:0] pc;
    } outcome_s;

    logic            clk = 1'b0;
    logic            reset_i = 1'b1;
    // Strobe held through reset must never reach the outputs
    logic            inst_valid_i = 1'b1;
    logic [XLEN-1:0] inst_i = {20'habcde, 5'd1, OPCODE_LUI};
    logic [XLEN-1:0] pc_i = '0;
    wb_s             wb_o;
    logic            dmem_req_o;
    logic [XLEN-1:0] dmem_addr_o;
    logic [XLEN-1:0] ex_pc_o;
    logic [XLEN-1:0] ex_inst_o;
    logic            issued_q = 1'b0;
    logic [XLEN-1:0] shadow [32] = '{default: '0};
    logic [XLEN-1:0] next_pc = 32'h0000_1000;
    logic [31:0]     lcg_state = 32'd4790;
    int              error_count = 0;
    outcome_s        expect_q [$];
    string           name_q [$];

    exec_slice_top dut_i (.*);

    bind exec_slice_top exec_slice_properties props_i (.*);

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ (lcg_state >> 15);
    endfunction

    // RV32I integer semantics
    function automatic logic [31:0] model_alu(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [31:0] fill;
        fill = {32{a[31]}} & ~(32'hffff_ffff >> b[4:0]);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'd0, (a[31] != b[31]) ? a[31] : (a < b)};
            3'd3: return {31'd0, a < b};
            3'd4: return a ^ b;
            3'd5: return (a >> b[4:0]) | (alt ? fill : 32'd0);
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] rand_inst(input logic [6:0] opc, input logic [4:0] rd,
                                              input logic [4:0] rs1, input logic [4:0] rs2);
        logic [31:0] r;
        r = next_rand();
        if (opc == OPCODE_LOAD) begin
            r[14:12] = 3'b010;
        end
        // Legal funct7 for OP and shifts with bit 5 picking SUB or SRA
        if (opc == OPCODE_OP || r[13:12] == 2'b01) begin
            r[31:25] = {1'b0, r[30] && (r[14:12] == 3'd0 || r[14:12] == 3'd5), 5'd0};
        end
        if (opc == OPCODE_OP) begin
            r[24:20] = rs2;
        end
        return {r[31:20], rs1, r[14:12], rd, opc};
    endfunction

    task automatic issue(input logic [31:0] w, input string test_name);
        logic [31:0] a;
        logic [31:0] imm;
        outcome_s    e;
        a = shadow[w[19:15]];
        imm = {{20{w[31]}}, w[31:20]};
        e = '0;
        e.inst = w;
        e.pc = next_pc;
        e.req = (w[6:0] == OPCODE_LOAD);
        case (w[6:0])
            OPCODE_OP:     e.data = model_alu(w[14:12], w[30], a, shadow[w[24:20]]);
            OPCODE_OP_IMM: e.data = model_alu(w[14:12], w[30] && w[14:12] == 3'd5, a, imm);
            OPCODE_LUI:    e.data = {w[31:12], 12'd0};
            OPCODE_AUIPC:  e.data = next_pc + {w[31:12], 12'd0};
            default:       e.data = a + imm;
        endcase
        e.wb_valid = !e.req && (w[11:7] != 5'd0);
        if (e.wb_valid) begin
            e.rd = w[11:7];
            shadow[e.rd] = e.data;
        end else if (!e.req) begin
            e.data = '0;
        end
        expect_q.push_back(e);
        name_q.push_back(test_name);
        @(posedge clk);
        inst_valid_i <= 1'b1;
        inst_i       <= w;
        pc_i         <= next_pc;
        next_pc = next_pc + 32'd4;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            inst_valid_i <= 1'b0;
        end
    endtask

    always @(posedge clk) begin
        issued_q <= inst_valid_i && !reset_i;
    end

    // Outputs settle after the rising edge
    always @(negedge clk) begin : compare_outputs
        outcome_s actual;
        outcome_s expected;
        string    test_name;
        actual.wb_valid = wb_o.valid;
        actual.req      = dmem_req_o;
        actual.rd       = wb_o.valid ? wb_o.rd : 5'd0;
        actual.data     = wb_o.valid ? wb_o.data : (dmem_req_o ? dmem_addr_o : '0);
        actual.inst     = ex_inst_o;
        actual.pc       = ex_pc_o;
        if (!reset_i && issued_q) begin
            expected = expect_q.pop_front();
            test_name = name_q.pop_front();
            outcome_match: assert (actual === expected) else begin
                $display("Fail %s: expected %h actual %h", test_name, expected, actual);
                error_count++;
            end
        end else if (!reset_i) begin
            quiet_when_idle: assert (!wb_o.valid && !dmem_req_o) else begin
                $display("Error: output active at %0t with no instruction issued", $time);
                error_count++;
            end
        end
    end

    initial begin : stimulus
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  dep;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_i <= 1'b0;
        inst_valid_i <= 1'b0;
        // No strobe yet
        idle(6);
        for (int i = 1; i < 32; i++) begin
            r = next_rand();
            issue({r[31:12], 5'(i), OPCODE_LUI}, "seed_lui");
            issue({r[11:0], 5'(i), 3'd0, 5'(i), OPCODE_OP_IMM}, "seed_addi");
        end
        for (int i = 0; i < N_RANDOM; i++) begin
            r = next_rand();
            case (r[2:0])
                3'd4, 3'd5: issue(rand_inst(OPCODE_OP_IMM, r[7:3], r[12:8], r[17:13]), "reg_imm");
                3'd6: issue({r[31:12], r[7:3], r[20] ? OPCODE_LUI : OPCODE_AUIPC}, "upper");
                3'd7: issue(rand_inst(OPCODE_LOAD, r[7:3], r[12:8], r[17:13]), "load");
                default: issue(rand_inst(OPCODE_OP, r[7:3], r[12:8], r[17:13]), "reg_reg");
            endcase
        end
        issue(rand_inst(OPCODE_OP, 5'd0, 5'd3, 5'd4), "rd_zero");
        dep = 5'd5;
        for (int i = 0; i < N_DEP; i++) begin
            r = next_rand();
            rd = r[5:1] | 5'd1;
            issue(rand_inst(r[0] ? OPCODE_OP : OPCODE_OP_IMM, rd, dep, dep), "dependent");
            dep = rd;
            // Alternate forwarding and register file reads
            if (i % 2 == 1) begin
                idle(1);
            end
        end
        idle(4);
        drained: assert (expect_q.size() == 0) else begin
            $display("Error: %0d instructions never produced a result", expect_q.size());
            error_count++;
        end
        $display("Summary: %0d value errors, %0d property failures", error_count,
                 dut_i.props_i.violations);
        if (error_count == 0 && dut_i.props_i.violations == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin : watchdog
        #((N_INSTS + N_IDLE + RESET_CYCLES) * CLK_PERIOD * 3);
        $display("Error: simulation timed out before the tests finished");
        $display("Checks failed");
        $finish;
    end

endmodule
